/* common/uart_cmd_config.svh */
`ifndef UART_CMD_CONFIG_SVH
`define UART_CMD_CONFIG_SVH

// clock cycles per serial bit, 4 or more
`define UC_BAUD_DIV 16

// start, eight data bits, odd parity, stop
`define UC_FRAME_BITS 11

// register bank size at the target
// the command address wraps modulo this count
`define UC_REG_COUNT 16

`endif

/* common/uart_cmd_pkg.sv */
`default_nettype none

`include "uart_cmd_config.svh"

package uart_cmd_pkg;

  // bit 15 read flag, 14:8 address, 7:0 write data
  typedef logic [15:0] cmd_t;
  typedef logic [7:0] byte_t;
  typedef logic [6:0] reg_addr_t;

  // parity error flag sits above the reply byte
  typedef logic [8:0] read_data_t;

  typedef logic [3:0] bit_cnt_t;
  typedef logic [$clog2(`UC_BAUD_DIV)-1:0] baud_cnt_t;

  typedef enum logic [1:0] {
    idle,
    send_header,
    send_data,
    wait_reply
  } host_state_t;

  typedef enum logic [1:0] {
    wait_header,
    wait_data,
    send_reply
  } target_state_t;

endpackage

`default_nettype wire

/* uart_host/uart_tx_frame.sv */
`default_nettype none

`include "uart_cmd_config.svh"

module uart_tx_frame (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       start,
  input  wire uart_cmd_pkg::byte_t  data,
  output logic                      tx,
  output logic                      busy,
  output logic                      done
);

  logic [`UC_FRAME_BITS-1:0] shreg;
  uart_cmd_pkg::baud_cnt_t   baud_cnt;
  uart_cmd_pkg::bit_cnt_t    bit_cnt;

  // bit 0 of the shift register is the line, ones fill in behind
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg    <= '1;
      busy     <= 1'b0;
      done     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        // stop, odd parity, data lsb first, start
        shreg    <= {1'b1, ~^data, data, 1'b0};
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end else if (busy) begin
        if (baud_cnt == uart_cmd_pkg::baud_cnt_t'(`UC_BAUD_DIV - 1)) begin
          baud_cnt <= '0;
          shreg    <= {1'b1, shreg[`UC_FRAME_BITS-1:1]};
          if (bit_cnt == uart_cmd_pkg::bit_cnt_t'(`UC_FRAME_BITS - 1)) begin
            // stop bit has run its full length
            busy <= 1'b0;
            done <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* uart_host/uart_rx_frame.sv */
`default_nettype none

`include "uart_cmd_config.svh"

module uart_rx_frame (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  rx,
  output logic                 valid,
  output uart_cmd_pkg::byte_t  data,
  output logic                 perr
);

  logic                    rx_meta;
  logic                    rx_sync;
  logic                    rx_prev;
  logic                    active;
  logic                    sample;
  uart_cmd_pkg::baud_cnt_t baud_cnt;
  uart_cmd_pkg::bit_cnt_t  bit_cnt;

  assign sample = active && (baud_cnt == uart_cmd_pkg::baud_cnt_t'(`UC_BAUD_DIV - 1));

  // data bits arrive lsb first at bit indices 1 to 8
  always_ff @(posedge clk) begin
    if (sample && bit_cnt != '0 && bit_cnt <= 4'd8) begin
      data <= {rx_sync, data[7:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      valid    <= 1'b0;
      perr     <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      valid   <= 1'b0;
      if (!active) begin
        // half a bit head start puts every sample at mid-bit
        if (rx_prev && !rx_sync) begin
          active   <= 1'b1;
          baud_cnt <= uart_cmd_pkg::baud_cnt_t'(`UC_BAUD_DIV / 2);
          bit_cnt  <= '0;
        end
      end else if (sample) begin
        baud_cnt <= '0;
        bit_cnt  <= bit_cnt + 1'b1;
        if (bit_cnt == '0) begin
          // start bit gone high again, just a glitch
          if (rx_sync) begin
            active <= 1'b0;
          end
        end else if (bit_cnt == 4'd9) begin
          perr <= ~^{data, rx_sync};
        end else if (bit_cnt == uart_cmd_pkg::bit_cnt_t'(`UC_FRAME_BITS - 1)) begin
          valid  <= 1'b1;
          active <= 1'b0;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* uart_host/uart_host.sv */
`default_nettype none

module uart_host (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire uart_cmd_pkg::cmd_t          cmd_in,
  input  wire                              cmd_vld,
  input  wire                              rx,
  output logic                             tx,
  output logic                             cmd_rdy,
  output logic                             read_rdy,
  output uart_cmd_pkg::read_data_t         read_data
);

  uart_cmd_pkg::host_state_t state;
  uart_cmd_pkg::cmd_t        cmd_q;

  logic                accept;
  logic                tx_start;
  logic                tx_done;
  uart_cmd_pkg::byte_t tx_data;
  logic                rx_valid;
  logic                rx_perr;
  uart_cmd_pkg::byte_t rx_data;

  assign cmd_rdy = (state == uart_cmd_pkg::idle);
  assign accept  = cmd_vld && cmd_rdy;

  // header goes out on the accept cycle, data byte right after header done
  assign tx_start = accept ||
                    (state == uart_cmd_pkg::send_header && tx_done && !cmd_q[15]);

  // header byte is the read flag plus address
  assign tx_data = (state == uart_cmd_pkg::idle) ? cmd_in[15:8] : cmd_q[7:0];

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= uart_cmd_pkg::idle;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        uart_cmd_pkg::idle: begin
          if (accept) begin
            state <= uart_cmd_pkg::send_header;
          end
        end
        uart_cmd_pkg::send_header: begin
          if (tx_done) begin
            if (cmd_q[15]) begin
              state <= uart_cmd_pkg::wait_reply;
            end else begin
              state <= uart_cmd_pkg::send_data;
            end
          end
        end
        uart_cmd_pkg::send_data: begin
          if (tx_done) begin
            state <= uart_cmd_pkg::idle;
          end
        end
        uart_cmd_pkg::wait_reply: begin
          // reply byte and its parity flag land together with the pulse
          if (rx_valid) begin
            read_data <= {rx_perr, rx_data};
            read_rdy  <= 1'b1;
            state     <= uart_cmd_pkg::idle;
          end
        end
        default: begin
          state <= uart_cmd_pkg::idle;
        end
      endcase
    end
  end

  uart_tx_frame u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_data),
    .tx    (tx),
    .busy  (),
    .done  (tx_done)
  );

  uart_rx_frame u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .valid (rx_valid),
    .data  (rx_data),
    .perr  (rx_perr)
  );

endmodule

`default_nettype wire

/* hw/reg_target.sv */
`default_nettype none

`include "uart_cmd_config.svh"

module reg_target (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   rx,
  output logic  tx
);

  localparam int idx_w = $clog2(`UC_REG_COUNT);

  uart_cmd_pkg::target_state_t state;
  uart_cmd_pkg::byte_t         bank [`UC_REG_COUNT];
  uart_cmd_pkg::reg_addr_t     hdr_addr;
  logic [idx_w-1:0]            hdr_idx;
  logic [idx_w-1:0]            addr_q;

  logic                rx_valid;
  logic                rx_perr;
  uart_cmd_pkg::byte_t rx_data;
  logic                tx_start;
  logic                tx_done;
  uart_cmd_pkg::byte_t tx_data;

  assign hdr_addr = rx_data[6:0];
  assign hdr_idx  = idx_w'(hdr_addr % `UC_REG_COUNT);

  // a clean read header starts the reply straight away
  assign tx_start = (state == uart_cmd_pkg::wait_header) && rx_valid && !rx_perr &&
                    rx_data[7];
  assign tx_data  = bank[hdr_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= uart_cmd_pkg::wait_header;
      addr_q <= '0;
      for (int i = 0; i < `UC_REG_COUNT; i++) begin
        bank[i] <= '0;
      end
    end else begin
      case (state)
        uart_cmd_pkg::wait_header: begin
          if (rx_valid && !rx_perr) begin
            if (rx_data[7]) begin
              state <= uart_cmd_pkg::send_reply;
            end else begin
              addr_q <= hdr_idx;
              state  <= uart_cmd_pkg::wait_data;
            end
          end
        end
        uart_cmd_pkg::wait_data: begin
          // a bad data frame is dropped and the write is lost
          if (rx_valid) begin
            if (!rx_perr) begin
              bank[addr_q] <= rx_data;
            end
            state <= uart_cmd_pkg::wait_header;
          end
        end
        uart_cmd_pkg::send_reply: begin
          if (tx_done) begin
            state <= uart_cmd_pkg::wait_header;
          end
        end
        default: begin
          state <= uart_cmd_pkg::wait_header;
        end
      endcase
    end
  end

  uart_rx_frame u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .valid (rx_valid),
    .data  (rx_data),
    .perr  (rx_perr)
  );

  uart_tx_frame u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_data),
    .tx    (tx),
    .busy  (),
    .done  (tx_done)
  );

endmodule

`default_nettype wire

/* hw/uart_cmd_top.sv */
`default_nettype none

module uart_cmd_top (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire uart_cmd_pkg::cmd_t   cmd_in,
  input  wire                       cmd_vld,
  output logic                      cmd_rdy,
  output logic                      read_rdy,
  output uart_cmd_pkg::read_data_t  read_data
);

  // serial nets between the two ends, both idle high
  logic host_to_target;
  logic target_to_host;

  uart_host u_host (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (target_to_host),
    .tx        (host_to_target),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  reg_target u_target (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (host_to_target),
    .tx    (target_to_host)
  );

endmodule

`default_nettype wire

/* tb/uart_cmd_checker.sv */
`default_nettype none

module uart_cmd_checker (
  input wire                               clk,
  input wire                               rst_n,
  input wire uart_cmd_pkg::host_state_t    state,
  input wire                               tx,
  input wire                               read_rdy,
  input wire uart_cmd_pkg::read_data_t     read_data
);

  // reply strobe is a single cycle wide
  a_read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy stayed high for more than one cycle");

  a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    (state == uart_cmd_pkg::idle) |-> tx)
    else $error("host tx line low while idle");

  // internal link has no noise, so parity never fails
  a_no_parity_error: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> !read_data[8])
    else $error("parity error flag set on the internal link");

endmodule

bind uart_host uart_cmd_checker u_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .state     (state),
  .tx        (tx),
  .read_rdy  (read_rdy),
  .read_data (read_data)
);

`default_nettype wire

/* tb/tb_uart_cmd.sv */
`default_nettype none

`include "uart_cmd_config.svh"

module tb_uart_cmd;

  localparam int num_entries  = 24;
  localparam int b2b_from     = 16;
  localparam int reset_cycles = 10;
  localparam int write_bound  = 22 * `UC_BAUD_DIV + 2;
  localparam int limit_cycles = num_entries * 40 * `UC_BAUD_DIV + reset_cycles;

  logic                      clk = 1'b0;
  logic                      rst_n;
  uart_cmd_pkg::cmd_t        cmd_in;
  logic                      cmd_vld;
  logic                      cmd_rdy;
  logic                      read_rdy;
  uart_cmd_pkg::read_data_t  read_data;

  // stimulus columns plus the predicted read result
  logic                      tbl_rd    [num_entries];
  uart_cmd_pkg::reg_addr_t   tbl_addr  [num_entries];
  uart_cmd_pkg::byte_t       tbl_data  [num_entries];
  logic                      tbl_extra [num_entries];
  uart_cmd_pkg::read_data_t  tbl_exp   [num_entries];
  uart_cmd_pkg::byte_t       model_bank [`UC_REG_COUNT];
  integer                    seed;
  int                        err_count;

  always #4 clk = ~clk;

  uart_cmd_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  task automatic report_failure();
    err_count++;
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_read_data(input string name, input uart_cmd_pkg::read_data_t got,
                                 input uart_cmd_pkg::read_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%03h expected 0x%03h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic set_entry(input int i, input logic rd, input uart_cmd_pkg::reg_addr_t addr,
                           input logic extra);
    logic [31:0] r;
    r = $random(seed);
    tbl_rd[i]    = rd;
    tbl_addr[i]  = addr;
    tbl_data[i]  = r[7:0];
    tbl_extra[i] = extra;
  endtask

  task automatic build_table();
    // reads of a fresh bank first, then aliasing and stray strobes
    set_entry(0, 1'b1, 7'h05, 1'b0);
    set_entry(1, 1'b1, 7'h7f, 1'b0);
    set_entry(2, 1'b0, 7'h03, 1'b0);
    set_entry(3, 1'b1, 7'h03, 1'b0);
    set_entry(4, 1'b0, 7'h13, 1'b0);
    set_entry(5, 1'b1, 7'h03, 1'b0);
    set_entry(6, 1'b0, 7'h2a, 1'b1);
    set_entry(7, 1'b1, 7'h0a, 1'b0);
    set_entry(8, 1'b0, 7'h4e, 1'b0);
    set_entry(9, 1'b1, 7'h0e, 1'b1);
    set_entry(10, 1'b1, 7'h6e, 1'b0);
    set_entry(11, 1'b0, 7'h00, 1'b0);
    set_entry(12, 1'b0, 7'h70, 1'b1);
    set_entry(13, 1'b1, 7'h10, 1'b0);
    set_entry(14, 1'b0, 7'h0e, 1'b0);
    set_entry(15, 1'b1, 7'h5e, 1'b0);
    // back-to-back run from here on
    set_entry(16, 1'b0, 7'h01, 1'b0);
    set_entry(17, 1'b1, 7'h01, 1'b0);
    set_entry(18, 1'b0, 7'h21, 1'b0);
    set_entry(19, 1'b0, 7'h02, 1'b0);
    set_entry(20, 1'b1, 7'h11, 1'b0);
    set_entry(21, 1'b1, 7'h02, 1'b0);
    set_entry(22, 1'b0, 7'h7f, 1'b0);
    set_entry(23, 1'b1, 7'h0f, 1'b0);
  endtask

  // register model, address wraps modulo the bank size
  task automatic predict_results();
    int idx;
    for (int k = 0; k < `UC_REG_COUNT; k++) begin
      model_bank[k] = '0;
    end
    for (int i = 0; i < num_entries; i++) begin
      idx = int'(tbl_addr[i]) % `UC_REG_COUNT;
      if (tbl_rd[i]) begin
        tbl_exp[i] = {1'b0, model_bank[idx]};
      end else begin
        model_bank[idx] = tbl_data[i];
        tbl_exp[i]      = '0;
      end
    end
  endtask

  function automatic uart_cmd_pkg::cmd_t make_cmd(input int i);
    return {tbl_rd[i], tbl_addr[i], tbl_data[i]};
  endfunction

  // called right after the accept edge, returns at the negedge where cmd_rdy is back
  task automatic follow_command(input int i, input logic hold_next);
    int   cycles;
    logic finished;
    cycles   = 0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk);
      cycles++;
      if (cycles == 1) begin
        check_flag("cmd_rdy", cmd_rdy, 1'b0);
      end
      check_flag("read_rdy", read_rdy, tbl_rd[i] & cmd_rdy);
      if (cmd_rdy) begin
        finished = 1'b1;
        if (tbl_rd[i]) begin
          check_read_data("read_data", read_data, tbl_exp[i]);
        end else begin
          check_flag("write_done_in_time", (cycles - 1) <= write_bound, 1'b1);
        end
      end else begin
        @(posedge clk);
        // stray write while busy, must be ignored
        if (tbl_extra[i] && !hold_next) begin
          if (cycles == 3) begin
            cmd_in  <= {1'b0, tbl_addr[i], tbl_data[i] ^ 8'hff};
            cmd_vld <= 1'b1;
          end else if (cycles == 4) begin
            cmd_vld <= 1'b0;
          end
        end
      end
    end
  endtask

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: command sequence did not finish within %0d cycles", limit_cycles);
    report_failure();
  end

  initial begin
    logic presented;
    err_count = 0;
    seed      = 32'h873b_2093;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    build_table();
    predict_results();
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("cmd_rdy", cmd_rdy, 1'b1);
    check_flag("read_rdy", read_rdy, 1'b0);
    presented = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      if (!presented) begin
        @(posedge clk);
        cmd_in  <= make_cmd(i);
        cmd_vld <= 1'b1;
        @(negedge clk);
        check_flag("cmd_rdy", cmd_rdy, 1'b1);
        check_flag("read_rdy", read_rdy, 1'b0);
      end
      // accept edge; next command may already wait on the bus
      @(posedge clk);
      presented = (i + 1 >= b2b_from) && (i + 1 < num_entries);
      if (presented) begin
        cmd_in <= make_cmd(i + 1);
      end else begin
        cmd_vld <= 1'b0;
      end
      follow_command(i, presented);
    end
    repeat (4) @(posedge clk);
    if (err_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/uart_cmd_pkg.sv
uart_host/uart_tx_frame.sv
uart_host/uart_rx_frame.sv
uart_host/uart_host.sv
hw/reg_target.sv
hw/uart_cmd_top.sv
tb/uart_cmd_checker.sv
tb/tb_uart_cmd.sv

/* run.sh */
#!/bin/sh
# compile and run the UART command bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_cmd \
  -f flist.f -o tb_uart_cmd_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_uart_cmd_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qF "All tests passed!" "$log"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
